// ==== bench/tb_model.svh ====
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

//////////////////////////////////////////////////
// Reference escape-time model

function automatic iter_t escape_count(input int a, input int b);
   coord_t  cr;
   coord_t  ci;
   zval_t   zr;
   zval_t   zi;
   zval_t   nr;
   zval_t   ni;
   longint  zr2;
   longint  zi2;
   longint  lim;
   int      n;
   logic    gone;
   cr   = coord_t'(-(2 << `MANDEL_FRAC) + (a << `MANDEL_STEP_SHIFT));
   ci   = coord_t'((2 << `MANDEL_FRAC) - (b << `MANDEL_STEP_SHIFT));   // Wraps at row 0
   lim  = longint'(4) << (2 * `MANDEL_FRAC);
   zr   = '0;
   zi   = '0;
   n    = 0;
   gone = 1'b0;
   while (!gone && n < `MANDEL_MAX_ITER) begin
      zr2 = longint'(zr) * longint'(zr);
      zi2 = longint'(zi) * longint'(zi);
      if (zr2 + zi2 > lim) begin
         gone = 1'b1;
      end else begin
         nr = zval_t'(((zr2 - zi2) >>> `MANDEL_FRAC) + longint'(cr));
         ni = zval_t'(((longint'(2) * longint'(zr) * longint'(zi)) >>> `MANDEL_FRAC)
                      + longint'(ci));
         zr = nr;
         zi = ni;
         n++;
      end
   end
   return iter_t'(n);
endfunction

function automatic pix_class_t escape_class(input iter_t n);
   if (n < 8)
      return 2'd0;
   else if (n < 16)
      return 2'd1;
   else if (n < 32)
      return 2'd2;
   return 2'd3;
endfunction

function automatic rgb_t class_colour(input pix_class_t c);
   case (c)
      2'd0:    return 6'b000011;
      2'd1:    return 6'b111100;
      2'd2:    return 6'b110000;
      default: return 6'b111111;
   endcase
endfunction

function automatic rgb_t pixel_colour(input int a, input int b);
   return class_colour(escape_class(escape_count(a, b)));
endfunction

//////////////////////////////////////////////////
// Compare tasks

task automatic check_rgb(input string name, input rgb_t exp, input rgb_t act);
   check_total++;
   if (act !== exp) begin
      mismatch_count++;
      $display("Mismatch in %s: expected %b, actual %b", name, exp, act);
   end
endtask

task automatic check_bit(input string name, input logic exp, input logic act);
   check_total++;
   if (act !== exp) begin
      mismatch_count++;
      $display("Mismatch in %s: expected %b, actual %b", name, exp, act);
   end
endtask

task automatic check_count(input string name, input longint exp, input longint act);
   check_total++;
   if (act != exp) begin
      mismatch_count++;
      $display("Mismatch in %s: expected %0d, actual %0d", name, exp, act);
   end
endtask

`endif

// ==== bench/tb_mandel.sv ====
`timescale 1ns/1ps
`include "mandel_defs.svh"

module tb_mandel import mandel_pkg::*; ();

   localparam int     CLK_PERIOD = 8;
   localparam int     H_TOTAL    = `VGA_HOR + `VGA_HOR_FP + `VGA_HOR_SP + `VGA_HOR_BP;
   localparam int     V_TOTAL    = `VGA_VER + `VGA_VER_FP + `VGA_VER_SP + `VGA_VER_BP + 1;
   localparam int     HS_START   = `VGA_HOR + `VGA_HOR_FP;
   localparam int     VS_START   = `VGA_VER + `VGA_VER_FP;
   localparam int     SIZE       = `MANDEL_SIZE;
   localparam int     SAMPLES    = 200;
   localparam longint WATCHDOG_CYCLES = longint'(30976) * 70 + 3 * 420000;

   logic          pll_clk;
   logic          i_nrst;
   logic          o_hs;
   logic          o_vs;
   logic [1:0]    o_r;
   logic [1:0]    o_g;
   logic [1:0]    o_b;
   logic          o_ready;
   rgb_t          rgb;

   int            check_total;
   int            mismatch_count;
   int            failure_count;
   int            sample_count;
   int unsigned   seed;
   longint        cyc;
   logic          ready_seen;
   logic          ready_dropped;
   logic          sel     [SIZE*SIZE];
   rgb_t          exp_rgb [SIZE*SIZE];

   `include "tb_model.svh"

   assign rgb = {o_r, o_g, o_b};

   mandel_top dut (
      .pll_clk (pll_clk),
      .i_nrst  (i_nrst ),
      .o_hs    (o_hs   ),
      .o_vs    (o_vs   ),
      .o_r     (o_r    ),
      .o_g     (o_g    ),
      .o_b     (o_b    ),
      .o_ready (o_ready)
   );

   always #(CLK_PERIOD / 2) pll_clk = ~pll_clk;

   always @(posedge pll_clk) cyc <= cyc + 1;

   // Ready is sticky once seen
   always @(negedge pll_clk) begin
      if (ready_seen && !ready_dropped && o_ready !== 1'b1) begin
         ready_dropped = 1'b1;
         check_bit("ready_hold", 1'b1, o_ready);
      end
   end

   task automatic print_counts();
      $display("Checks: %0d, mismatches: %0d, other failures: %0d",
               check_total, mismatch_count, failure_count);
   endtask

   task automatic wait_sync_edge(input logic use_vs, input logic level, output longint t);
      logic prev;
      logic cur;
      logic found;
      prev  = use_vs ? o_vs : o_hs;
      found = 1'b0;
      while (!found) begin
         @(negedge pll_clk);
         cur   = use_vs ? o_vs : o_hs;
         found = (cur === level) && (prev !== level);
         prev  = cur;
      end
      t = cyc;
   endtask

   task automatic reset_outputs(input string name);
      check_bit({name, " hs"}, 1'b1, o_hs);
      check_bit({name, " vs"}, 1'b1, o_vs);
      check_rgb({name, " rgb"}, 6'b0, rgb);
      check_bit({name, " ready"}, 1'b0, o_ready);
   endtask

   task automatic verify_reset_state();
      repeat (9) begin
         @(posedge pll_clk);
         @(negedge pll_clk);
         reset_outputs("reset_hold");
      end
      @(posedge pll_clk);
      i_nrst <= 1'b1;
      repeat (2) begin
         @(negedge pll_clk);
         reset_outputs("reset_release");
      end
   endtask

   task automatic measure_sync_timing();
      longint t0;
      longint t1;
      longint t2;
      wait_sync_edge(1'b0, 1'b0, t0);
      wait_sync_edge(1'b0, 1'b1, t1);
      wait_sync_edge(1'b0, 1'b0, t2);
      check_count("hs_pulse", `VGA_HOR_SP, t1 - t0);
      check_count("hs_period", H_TOTAL, t2 - t0);
      wait_sync_edge(1'b1, 1'b0, t0);
      wait_sync_edge(1'b1, 1'b1, t1);
      wait_sync_edge(1'b1, 1'b0, t2);
      check_count("vs_pulse", `VGA_VER_SP * H_TOTAL, t1 - t0);      // In cycles
      check_count("vs_period", V_TOTAL * H_TOTAL, t2 - t0);
   endtask

   task automatic await_render();
      while (o_ready !== 1'b1)
         @(negedge pll_clk);
      ready_seen = 1'b1;
      $display("Render complete at cycle %0d", cyc);
   endtask

   task automatic mark_pixel(input int a, input int b);
      if (!sel[b*SIZE + a]) begin
         sel[b*SIZE + a]     = 1'b1;
         exp_rgb[b*SIZE + a] = pixel_colour(a, b);
         sample_count++;
      end
   endtask

   task automatic pick_samples();
      for (int i = 0; i < SIZE*SIZE; i++)
         sel[i] = 1'b0;
      sample_count = 0;
      mark_pixel(0, 0);
      mark_pixel(SIZE - 1, 0);
      mark_pixel(0, SIZE - 1);
      mark_pixel(SIZE - 1, SIZE - 1);
      while (sample_count < SAMPLES + 4)
         mark_pixel($urandom % SIZE, $urandom % SIZE);
   endtask

   //////////////////////////////////////////////////
   // One frame, position tracked from the sync edges

   task automatic scan_frame();
      int      col;
      int      row;
      int      seen;
      longint  left;
      logic    prev_hs;
      logic    prev_vs;
      logic    checking;
      col      = -1;
      row      = -1;
      seen     = 0;
      left     = longint'(H_TOTAL) * V_TOTAL;
      checking = 1'b0;
      prev_hs  = o_hs;
      prev_vs  = o_vs;
      while (left > 0) begin
         @(negedge pll_clk);
         if (prev_hs && !o_hs)
            col = HS_START;
         else if (col >= 0)
            col = (col + 1) % H_TOTAL;
         if (prev_vs && !o_vs)
            row = VS_START;                      // vs falls at column 0
         else if (row >= 0 && col == 0)
            row = (row + 1) % V_TOTAL;
         prev_hs = o_hs;
         prev_vs = o_vs;
         if (col == 0 && row == 0)
            checking = 1'b1;                     // Origin found
         if (checking) begin
            left--;
            if (!o_hs || !o_vs)
               check_rgb("blank_sync", 6'b0, rgb);
            else if (col >= SIZE || row >= SIZE)
               check_rgb($sformatf("blank_outside (%0d,%0d)", col, row), 6'b0, rgb);
            else if (sel[row*SIZE + col]) begin
               check_rgb($sformatf("image (%0d,%0d)", col, row), exp_rgb[row*SIZE + col], rgb);
               seen++;
            end
         end
      end
      if (seen != sample_count) begin
         failure_count++;
         $display("Image check saw %0d of %0d sample pixels", seen, sample_count);
      end
   endtask

   initial begin
      pll_clk        = 1'b0;
      i_nrst         = 1'b0;
      cyc            = 0;
      check_total    = 0;
      mismatch_count = 0;
      failure_count  = 0;
      ready_seen     = 1'b0;
      ready_dropped  = 1'b0;
      seed           = 32'h4deb;
      seed           = $urandom(seed);
      verify_reset_state();
      measure_sync_timing();
      await_render();
      pick_samples();
      scan_frame();
      print_counts();
      if (mismatch_count == 0 && failure_count == 0)
         $display("Simulation finished: PASS");
      else
         $display("Simulation finished: FAIL");
      $finish;
   end

   // Worst-case render plus three frames
   initial begin
      #(WATCHDOG_CYCLES * CLK_PERIOD);
      failure_count++;
      $display("Timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
      print_counts();
      $display("Simulation finished: FAIL");
      $finish;
   end

endmodule

// ==== hdl/frame_buffer.sv ====
`timescale 1ns/1ps
`include "mandel_defs.svh"

module frame_buffer import mandel_pkg::*; (
   input  logic         pll_clk,
   input  logic         i_nrst,
   result_if.fb         res,
   input  fb_addr_t     i_raddr,
   output pix_class_t   o_rdata,
   output logic         o_ready
);

   localparam int BANK_AW = $clog2(`FB_BANK_DEPTH);
   localparam int BANK_SW = $clog2(`FB_BANKS);

   pix_class_t          bank_rdata [`FB_BANKS];
   logic [BANK_SW-1:0]  rd_bank;
   logic                ready;

   //////////////////////////////////////////////////
   // Banks, upper address bits pick the bank

   for (genvar i = 0; i < `FB_BANKS; i++) begin : g_bank
      pix_class_t mem [`FB_BANK_DEPTH];
      pix_class_t rdata_q;
      logic       we;

      assign we = res.wr_valid && (res.wr_addr[BANK_AW +: BANK_SW] == BANK_SW'(i));

      always_ff @(posedge pll_clk) begin
         if (we)
            mem[res.wr_addr[BANK_AW-1:0]] <= res.wr_class;
         rdata_q <= mem[i_raddr[BANK_AW-1:0]];
      end

      assign bank_rdata[i] = rdata_q;
   end

   // Bank index follows the read address by one cycle
   always_ff @(posedge pll_clk or negedge i_nrst) begin
      if (!i_nrst)
         rd_bank <= '0;
      else
         rd_bank <= i_raddr[BANK_AW +: BANK_SW];
   end

   assign o_rdata = bank_rdata[rd_bank];

   always_ff @(posedge pll_clk or negedge i_nrst) begin
      if (!i_nrst)
         ready <= 1'b0;
      else if (res.wr_valid && res.done_last)
         ready <= 1'b1;   // Sticky
   end

   assign o_ready = ready;

endmodule

// ==== hdl/mandel_defs.svh ====
`ifndef MANDEL_DEFS_SVH
`define MANDEL_DEFS_SVH

// Image and iteration
`define MANDEL_SIZE           176
`define MANDEL_MAX_ITER       64
`define MANDEL_QUEUE_DEPTH    2
`define MANDEL_FRAC           14
`define MANDEL_STEP_SHIFT     8      // 1/64 per pixel

// 640x480 timing
`define VGA_HOR               640
`define VGA_HOR_FP            16
`define VGA_HOR_SP            96
`define VGA_HOR_BP            48

`define VGA_VER               480
`define VGA_VER_FP            11
`define VGA_VER_SP            2
`define VGA_VER_BP            31

// Frame buffer banking
`define FB_BANKS              16
`define FB_BANK_DEPTH         2048

`endif

// ==== hdl/mandel_ifs.sv ====
`timescale 1ns/1ps

//////////////////////////////////////////////////
// Scanner to core, credit flow control

interface point_if import mandel_pkg::*; ();

   logic       point_valid;
   coord_t     c_re;
   coord_t     c_im;
   fb_addr_t   addr;
   logic       credit_return;   // One pulse per pop

   modport scanner (
      output point_valid,
      output c_re,
      output c_im,
      output addr,
      input  credit_return
   );

   modport core (
      input  point_valid,
      input  c_re,
      input  c_im,
      input  addr,
      output credit_return
   );

endinterface

//////////////////////////////////////////////////
// Core to frame buffer, no back-pressure

interface result_if import mandel_pkg::*; ();

   logic          wr_valid;
   fb_addr_t      wr_addr;
   pix_class_t    wr_class;
   logic          done_last;

   modport core (
      output wr_valid,
      output wr_addr,
      output wr_class,
      output done_last
   );

   modport fb (
      input  wr_valid,
      input  wr_addr,
      input  wr_class,
      input  done_last
   );

endinterface

// ==== hdl/mandel_pkg.sv ====
package mandel_pkg;

   // Fixed point
   typedef logic signed [15:0]   coord_t;       // Q2.14
   typedef logic signed [17:0]   zval_t;        // Q4.14

   typedef logic [6:0]           iter_t;
   typedef logic [1:0]           pix_class_t;
   typedef logic [14:0]          fb_addr_t;     // row * 176 + col
   typedef logic [9:0]           scr_pos_t;
   typedef logic [5:0]           rgb_t;         // {r, g, b}
   typedef logic [1:0]           credit_t;

   typedef enum logic [1:0] {
      CORE_IDLE,
      CORE_ITER,
      CORE_WRITE
   } core_state_t;

   typedef enum logic {
      SCAN_RUN,
      SCAN_DONE
   } scan_state_t;

endpackage

// ==== hdl/mandel_top.sv ====
`timescale 1ns/1ps

module mandel_top import mandel_pkg::*; (
   input  logic         pll_clk,
   input  logic         i_nrst,
   output logic         o_hs,
   output logic         o_vs,
   output logic [1:0]   o_r,
   output logic [1:0]   o_g,
   output logic [1:0]   o_b,
   output logic         o_ready
);

   fb_addr_t      raddr;
   pix_class_t    rdata;

   point_if    pt_bus  ();
   result_if   res_bus ();

   //////////////////////////////////////////////////
   // Render path

   point_scanner u_scanner (
      .pll_clk    (pll_clk             ),
      .i_nrst     (i_nrst              ),
      .pt         (pt_bus.scanner      )
   );

   mandelbrot_core u_core (
      .pll_clk    (pll_clk             ),
      .i_nrst     (i_nrst              ),
      .pt         (pt_bus.core         ),
      .res        (res_bus.core        )
   );

   frame_buffer u_fb (
      .pll_clk    (pll_clk             ),
      .i_nrst     (i_nrst              ),
      .res        (res_bus.fb          ),
      .i_raddr    (raddr               ),
      .o_rdata    (rdata               ),
      .o_ready    (o_ready             )
   );

   // Display path
   vga_scanout u_vga (
      .pll_clk    (pll_clk             ),
      .i_nrst     (i_nrst              ),
      .i_rdata    (rdata               ),
      .o_raddr    (raddr               ),
      .o_hs       (o_hs                ),
      .o_vs       (o_vs                ),
      .o_rgb      ({o_r, o_g, o_b}     )
   );

endmodule

// ==== hdl/mandelbrot_core.sv ====
`timescale 1ns/1ps
`include "mandel_defs.svh"

module mandelbrot_core import mandel_pkg::*; (
   input  logic      pll_clk,
   input  logic      i_nrst,
   point_if.core     pt,
   result_if.core    res
);

   localparam int                 PTR_W     = $clog2(`MANDEL_QUEUE_DEPTH);
   localparam int                 CNT_W     = $clog2(`MANDEL_QUEUE_DEPTH + 1);
   localparam fb_addr_t           LAST_ADDR = fb_addr_t'(`MANDEL_SIZE * `MANDEL_SIZE - 1);
   localparam iter_t              MAX_ITER  = iter_t'(`MANDEL_MAX_ITER);
   localparam logic signed [35:0] ESC_LIMIT = 36'sd4 <<< (2 * `MANDEL_FRAC);   // 4.0

   // Point queue
   coord_t              q_re   [`MANDEL_QUEUE_DEPTH];
   coord_t              q_im   [`MANDEL_QUEUE_DEPTH];
   fb_addr_t            q_addr [`MANDEL_QUEUE_DEPTH];
   logic [PTR_W-1:0]    wr_ptr;
   logic [PTR_W-1:0]    rd_ptr;
   logic [CNT_W-1:0]    q_count;
   logic                pop;

   // Engine
   core_state_t         state;
   coord_t              cr;
   coord_t              ci;
   fb_addr_t            cur_addr;
   zval_t               zr;
   zval_t               zi;
   iter_t               iter;
   logic signed [35:0]  zr2;
   logic signed [35:0]  zi2;
   logic signed [35:0]  zri;
   logic signed [35:0]  mag;
   logic                escaped;
   logic                step;

   //////////////////////////////////////////////////
   // Queue, depth matches the scanner's credits

   assign pop              = (state == CORE_IDLE) && (q_count != '0);
   assign pt.credit_return = pop;

   always_ff @(posedge pll_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         wr_ptr  <= '0;
         rd_ptr  <= '0;
         q_count <= '0;
      end else begin
         if (pt.point_valid)
            wr_ptr <= wr_ptr + 1'b1;
         if (pop)
            rd_ptr <= rd_ptr + 1'b1;
         if (pt.point_valid && !pop)
            q_count <= q_count + 1'b1;
         else if (pop && !pt.point_valid)
            q_count <= q_count - 1'b1;
      end
   end

   always_ff @(posedge pll_clk) begin
      if (pt.point_valid) begin
         q_re[wr_ptr]   <= pt.c_re;
         q_im[wr_ptr]   <= pt.c_im;
         q_addr[wr_ptr] <= pt.addr;
      end
   end

   //////////////////////////////////////////////////
   // Escape-time iteration

   assign zr2     = zr * zr;
   assign zi2     = zi * zi;
   assign zri     = zr * zi;
   assign mag     = zr2 + zi2;
   assign escaped = mag > ESC_LIMIT;
   assign step    = (state == CORE_ITER) && !escaped && (iter != MAX_ITER);

   always_ff @(posedge pll_clk or negedge i_nrst) begin
      if (!i_nrst)
         state <= CORE_IDLE;
      else begin
         case (state)
            CORE_IDLE:  if (pop) state <= CORE_ITER;
            CORE_ITER:  if (!step) state <= CORE_WRITE;
            CORE_WRITE: state <= CORE_IDLE;
            default:    state <= CORE_IDLE;
         endcase
      end
   end

   always_ff @(posedge pll_clk) begin
      if (pop) begin
         cr       <= q_re[rd_ptr];
         ci       <= q_im[rd_ptr];
         cur_addr <= q_addr[rd_ptr];
         zr       <= '0;
         zi       <= '0;
         iter     <= '0;
      end else if (step) begin
         zr   <= zval_t'((zr2 - zi2) >>> `MANDEL_FRAC) + zval_t'(cr);
         zi   <= zval_t'(zri >>> (`MANDEL_FRAC - 1)) + zval_t'(ci);   // 2*zr*zi
         iter <= iter + 1'b1;
      end
   end

   // Result
   assign res.wr_valid  = (state == CORE_WRITE);
   assign res.wr_addr   = cur_addr;
   assign res.done_last = res.wr_valid && (cur_addr == LAST_ADDR);

   always_comb begin
      if (iter < iter_t'(8))
         res.wr_class = 2'd0;
      else if (iter < iter_t'(16))
         res.wr_class = 2'd1;
      else if (iter < iter_t'(32))
         res.wr_class = 2'd2;
      else
         res.wr_class = 2'd3;
   end

endmodule

// ==== hdl/point_scanner.sv ====
`timescale 1ns/1ps
`include "mandel_defs.svh"

module point_scanner import mandel_pkg::*; (
   input  logic      pll_clk,
   input  logic      i_nrst,
   point_if.scanner  pt
);

   localparam coord_t      C_ORIGIN  = 16'h8000;   // -2.0, wraps for im
   localparam fb_addr_t    LAST_ADDR = fb_addr_t'(`MANDEL_SIZE * `MANDEL_SIZE - 1);
   localparam logic [7:0]  LAST_POS  = 8'(`MANDEL_SIZE - 1);

   scan_state_t   state;
   credit_t       credits;
   logic [7:0]    a;          // Column
   logic [7:0]    b;          // Row
   fb_addr_t      lin_addr;
   logic          issue;
   logic          a_wrap;

   assign issue  = (state == SCAN_RUN) && (credits != '0);
   assign a_wrap = (a == LAST_POS);

   // Row-major walk, linear address tracks b * 176 + a
   always_ff @(posedge pll_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         state    <= SCAN_RUN;
         a        <= '0;
         b        <= '0;
         lin_addr <= '0;
      end else if (issue) begin
         a        <= a_wrap ? '0 : a + 8'd1;
         lin_addr <= lin_addr + 1'b1;
         if (a_wrap)
            b <= b + 8'd1;
         if (lin_addr == LAST_ADDR)
            state <= SCAN_DONE;   // Nothing more after (175, 175)
      end
   end

   always_ff @(posedge pll_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         credits        <= credit_t'(`MANDEL_QUEUE_DEPTH);
         pt.point_valid <= 1'b0;
      end else begin
         pt.point_valid <= issue;
         case ({issue, pt.credit_return})
            2'b10:   credits <= credits - 1'b1;
            2'b01:   credits <= credits + 1'b1;
            default: ;                          // Spend and return cancel
         endcase
      end
   end

   always_ff @(posedge pll_clk) begin
      if (issue) begin
         pt.c_re <= C_ORIGIN + coord_t'({8'd0, a} << `MANDEL_STEP_SHIFT);
         pt.c_im <= C_ORIGIN - coord_t'({8'd0, b} << `MANDEL_STEP_SHIFT);
         pt.addr <= lin_addr;
      end
   end

endmodule

// ==== hdl/vga_scanout.sv ====
`timescale 1ns/1ps
`include "mandel_defs.svh"

module vga_scanout import mandel_pkg::*; (
   input  logic         pll_clk,
   input  logic         i_nrst,
   input  pix_class_t   i_rdata,
   output fb_addr_t     o_raddr,
   output logic         o_hs,
   output logic         o_vs,
   output rgb_t         o_rgb
);

   // Line: visible, front porch, sync, back porch
   localparam scr_pos_t H_SYNC_ON  = scr_pos_t'(`VGA_HOR + `VGA_HOR_FP);
   localparam scr_pos_t H_SYNC_OFF = scr_pos_t'(`VGA_HOR + `VGA_HOR_FP + `VGA_HOR_SP);
   localparam scr_pos_t H_LAST     = scr_pos_t'(`VGA_HOR + `VGA_HOR_FP + `VGA_HOR_SP
                                                + `VGA_HOR_BP - 1);

   localparam scr_pos_t V_SYNC_ON  = scr_pos_t'(`VGA_VER + `VGA_VER_FP);
   localparam scr_pos_t V_SYNC_OFF = scr_pos_t'(`VGA_VER + `VGA_VER_FP + `VGA_VER_SP);
   // One extra back porch line, 525 in all
   localparam scr_pos_t V_LAST     = scr_pos_t'(`VGA_VER + `VGA_VER_FP + `VGA_VER_SP
                                                + `VGA_VER_BP);

   localparam scr_pos_t SIZE       = scr_pos_t'(`MANDEL_SIZE);

   scr_pos_t   h_cnt;
   scr_pos_t   v_cnt;
   scr_pos_t   h_next;
   scr_pos_t   v_next;
   logic       h_wrap;
   logic       in_sq;
   rgb_t       pal;

   //////////////////////////////////////////////////
   // Counters, next position drives the RAM read

   assign h_wrap = (h_cnt == H_LAST);
   assign h_next = h_wrap ? '0 : h_cnt + 1'b1;

   always_comb begin
      if (!h_wrap)
         v_next = v_cnt;
      else if (v_cnt == V_LAST)
         v_next = '0;
      else
         v_next = v_cnt + 1'b1;
   end

   assign o_raddr = fb_addr_t'(v_next) * fb_addr_t'(`MANDEL_SIZE) + fb_addr_t'(h_next);

   always_ff @(posedge pll_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         h_cnt <= '0;
         v_cnt <= '0;
         in_sq <= 1'b0;
      end else begin
         h_cnt <= h_next;
         v_cnt <= v_next;
         in_sq <= (h_next < SIZE) && (v_next < SIZE);   // Aligns with RAM data
      end
   end

   //////////////////////////////////////////////////
   // Palette and output registers

   always_comb begin
      case (i_rdata)
         2'd0:    pal = 6'b000011;   // Blue
         2'd1:    pal = 6'b111100;   // Yellow
         2'd2:    pal = 6'b110000;   // Red
         default: pal = 6'b111111;   // White
      endcase
   end

   always_ff @(posedge pll_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         o_hs  <= 1'b1;
         o_vs  <= 1'b1;
         o_rgb <= '0;
      end else begin
         o_hs  <= !((h_cnt >= H_SYNC_ON) && (h_cnt < H_SYNC_OFF));
         o_vs  <= !((v_cnt >= V_SYNC_ON) && (v_cnt < V_SYNC_OFF));
         o_rgb <= in_sq ? pal : '0;   // Black outside the square
      end
   end

endmodule

// ==== src.f ====
+incdir+hdl
+incdir+bench
hdl/mandel_pkg.sv
hdl/mandel_ifs.sv
hdl/point_scanner.sv
hdl/mandelbrot_core.sv
hdl/frame_buffer.sv
hdl/vga_scanout.sv
hdl/mandel_top.sv
bench/tb_mandel.sv
